//--- src/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int WORD_BITS     = 32;
    localparam int LINE_WORDS    = 4;
    localparam int WAYS          = 4;
    localparam int SETS          = 64;
    localparam int OFFSET_BITS   = 4;
    localparam int INDEX_BITS    = 6;
    localparam int TAG_BITS      = 22;
    localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);
    localparam int BYTE_OFF_BITS = OFFSET_BITS - WORD_SEL_BITS;

    typedef logic [31:0]                          addr_t;
    typedef logic [WORD_BITS-1:0]                 word_t;
    typedef logic [WORD_BITS/8-1:0]               strb_t;
    typedef logic [TAG_BITS-1:0]                  tag_t;
    typedef logic [INDEX_BITS-1:0]                index_t;
    typedef logic [WORD_SEL_BITS-1:0]             word_sel_t;
    typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] line_t;
    typedef logic [WAYS-1:0]                      way_vec_t;
    typedef logic [$clog2(WAYS)-1:0]              way_idx_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    // miss handling sequence
    typedef enum logic [2:0] {
        st_lookup,
        st_miss_dirty,
        st_writeback,
        st_miss_clean,
        st_refill,
        st_refill_done
    } ctrl_state_t;

    function automatic tag_t get_tag(input addr_t addr);
        return addr[31 -: TAG_BITS];
    endfunction

    function automatic index_t get_index(input addr_t addr);
        return addr[OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic word_sel_t get_word(input addr_t addr);
        return addr[BYTE_OFF_BITS +: WORD_SEL_BITS];
    endfunction

    // byte lanes with strobe set take the store data
    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input strb_t strb);
        word_t result;
        result = old_word;
        for (int b = 0; b < WORD_BITS / 8; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage

//--- src/lutram.sv
`timescale 1ns/10ps

module lutram import dcache_pkg::*; #(
    parameter type dtype = logic
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   we,
    input  index_t addr,
    input  dtype   din,
    output dtype   dout
);

    dtype mem [SETS];

    // whole array is cleared so valid and dirty bits start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= din;
        end
    end

    // asynchronous read port
    assign dout = mem[addr];

endmodule

//--- src/cache_way.sv
`timescale 1ns/10ps

module cache_way import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  index_t    index,
    input  tag_t      tag,
    input  logic      tagv_we,
    input  logic      dirty_we,
    input  logic      dirty_in,
    input  logic      data_we,
    input  logic      word_we,
    input  word_sel_t word_sel,
    input  line_t     wdata_line,
    input  word_t     wdata_word,
    output logic      hit,
    output tagv_t     tagv,
    output logic      dirty,
    output line_t     line
);

    tagv_t tagv_din;
    line_t line_din;

    // a refill always installs a valid entry for the current tag
    assign tagv_din = '{valid: 1'b1, tag: tag};

    // full line on refill, otherwise a single word patched into the stored line
    always_comb begin
        line_din = line;
        if (data_we) begin
            line_din = wdata_line;
        end else begin
            line_din[word_sel] = wdata_word;
        end
    end

    lutram #(.dtype(tagv_t)) u_tagv (
        .clk  (clk),
        .rst  (rst),
        .we   (tagv_we),
        .addr (index),
        .din  (tagv_din),
        .dout (tagv)
    );

    lutram #(.dtype(logic)) u_dirty (
        .clk  (clk),
        .rst  (rst),
        .we   (dirty_we),
        .addr (index),
        .din  (dirty_in),
        .dout (dirty)
    );

    lutram #(.dtype(line_t)) u_data (
        .clk  (clk),
        .rst  (rst),
        .we   (data_we | word_we),
        .addr (index),
        .din  (line_din),
        .dout (line)
    );

    assign hit = tagv.valid && (tagv.tag == tag);

endmodule

//--- src/plru_table.sv
`timescale 1ns/10ps

module plru_table import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  index_t   index,
    input  logic     access,
    input  way_idx_t access_way,
    output way_idx_t victim
);

    // bit 0 picks the pair, bit 1 within ways 0/1, bit 2 within ways 2/3
    logic [2:0] tree [SETS];
    logic [2:0] cur_bits;
    logic [2:0] new_bits;

    assign cur_bits = tree[index];

    // walk from the root toward the least recently used leaf
    assign victim[1] = cur_bits[0];
    assign victim[0] = cur_bits[0] ? cur_bits[2] : cur_bits[1];

    // point every node on the accessed path away from that way
    always_comb begin
        new_bits    = cur_bits;
        new_bits[0] = ~access_way[1];
        if (access_way[1]) begin
            new_bits[2] = ~access_way[0];
        end else begin
            new_bits[1] = ~access_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SETS; i++) begin
                tree[i] <= '0;
            end
        end else if (access) begin
            tree[index] <= new_bits;
        end
    end

endmodule

//--- src/way_select.sv
`timescale 1ns/10ps

module way_select import dcache_pkg::*; (
    input  way_vec_t  hits,
    input  tagv_t     tagvs [WAYS],
    input  way_vec_t  dirtys,
    input  line_t     lines [WAYS],
    input  word_sel_t word_sel,
    input  word_t     wdata,
    input  strb_t     wstrb,
    input  way_idx_t  victim,
    output logic      hit,
    output way_idx_t  hit_way,
    output word_t     rdata,
    output word_t     merged,
    output logic      victim_dirty,
    output tag_t      victim_tag,
    output line_t     victim_line
);

    line_t hit_line;

    assign hit = |hits;

    // at most one way hits, so a priority encode is enough
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (hits[i]) begin
                hit_way = way_idx_t'(i);
            end
        end
    end

    assign hit_line = lines[hit_way];
    assign rdata    = hit_line[word_sel];

    // store data merged over the current word
    assign merged = merge_bytes(rdata, wdata, wstrb);

    // only a valid dirty victim needs a writeback
    assign victim_dirty = dirtys[victim] & tagvs[victim].valid;
    assign victim_tag   = tagvs[victim].tag;
    assign victim_line  = lines[victim];

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // cpu port
    input  logic      req,
    input  logic      we,
    input  addr_t     addr,
    input  word_t     wdata,
    input  strb_t     wstrb,
    output logic      busy,
    output logic      done,
    output word_t     rdata,

    // memory port
    output logic      mem_rd_req,
    output addr_t     mem_rd_addr,
    input  logic      mem_rd_rdy,
    input  logic      mem_ret_valid,
    input  line_t     mem_ret_line,
    output logic      mem_wr_req,
    output addr_t     mem_wr_addr,
    output line_t     mem_wr_line,
    input  logic      mem_wr_rdy,
    input  logic      mem_wr_done,

    // from way_select and plru_table
    input  logic      hit,
    input  way_idx_t  hit_way,
    input  word_t     sel_rdata,
    input  word_t     merged,
    input  way_idx_t  victim,
    input  logic      victim_dirty,
    input  tag_t      victim_tag,
    input  line_t     victim_line,

    // to way_select
    output word_t     req_wdata,
    output strb_t     req_wstrb,

    // to the ways
    output index_t    index,
    output tag_t      tag,
    output word_sel_t word_sel,
    output way_vec_t  tagv_we,
    output way_vec_t  dirty_we,
    output way_vec_t  data_we,
    output way_vec_t  word_we,
    output logic      dirty_in,
    output line_t     wdata_line,
    output word_t     wdata_word,

    // to the plru table
    output logic      plru_access,
    output way_idx_t  plru_way
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    // registered request
    logic  r_valid;
    logic  r_we;
    addr_t r_addr;
    word_t r_wdata;
    strb_t r_wstrb;

    logic accept;
    logic lookup_cycle;
    logic refill_write;
    logic store_write;

    assign accept = req && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (accept) begin
            r_valid <= 1'b1;
        end else if (done) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            r_we    <= we;
            r_addr  <= addr;
            r_wdata <= wdata;
            r_wstrb <= wstrb;
        end
    end

    assign index    = get_index(r_addr);
    assign tag      = get_tag(r_addr);
    assign word_sel = get_word(r_addr);

    // registered store data for the byte merge
    assign req_wdata = r_wdata;
    assign req_wstrb = r_wstrb;

    // first lookup, or the repeated lookup after a refill
    assign lookup_cycle = (state == st_lookup) || (state == st_refill_done);

    assign done  = r_valid && hit && lookup_cycle;
    assign busy  = (state != st_lookup) || (r_valid && !hit);
    assign rdata = sel_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_lookup;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_lookup: begin
                if (r_valid && !hit) begin
                    state_next = victim_dirty ? st_miss_dirty : st_miss_clean;
                end
            end
            st_miss_dirty: begin
                if (mem_wr_rdy) begin
                    state_next = st_writeback;
                end
            end
            st_writeback: begin
                if (mem_wr_done) begin
                    state_next = st_miss_clean;
                end
            end
            st_miss_clean: begin
                if (mem_rd_rdy) begin
                    state_next = st_refill;
                end
            end
            st_refill: begin
                if (mem_ret_valid) begin
                    state_next = st_refill_done;
                end
            end
            st_refill_done: begin
                state_next = st_lookup;
            end
            default: begin
                state_next = st_lookup;
            end
        endcase
    end

    // memory requests are levels held by the state
    assign mem_wr_req  = (state == st_miss_dirty);
    assign mem_wr_addr = {victim_tag, index, {OFFSET_BITS{1'b0}}};
    assign mem_wr_line = victim_line;
    assign mem_rd_req  = (state == st_miss_clean);
    assign mem_rd_addr = {tag, index, {OFFSET_BITS{1'b0}}};

    assign refill_write = (state == st_refill) && mem_ret_valid;
    assign store_write  = done && r_we;

    // refill lands in the victim way, stores in the hit way
    always_comb begin
        tagv_we  = '0;
        dirty_we = '0;
        data_we  = '0;
        word_we  = '0;
        if (refill_write) begin
            tagv_we[victim]  = 1'b1;
            data_we[victim]  = 1'b1;
            dirty_we[victim] = 1'b1;
        end else if (store_write) begin
            word_we[hit_way]  = 1'b1;
            dirty_we[hit_way] = 1'b1;
        end
    end

    // a refilled line starts clean
    assign dirty_in   = !refill_write;
    assign wdata_line = mem_ret_line;
    assign wdata_word = merged;

    assign plru_access = done;
    assign plru_way    = hit_way;

endmodule

//--- src/dcache_top.sv
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  req,
    input  logic  we,
    input  addr_t addr,
    input  word_t wdata,
    input  strb_t wstrb,
    output logic  busy,
    output logic  done,
    output word_t rdata,
    output logic  mem_rd_req,
    output addr_t mem_rd_addr,
    input  logic  mem_rd_rdy,
    input  logic  mem_ret_valid,
    input  line_t mem_ret_line,
    output logic  mem_wr_req,
    output addr_t mem_wr_addr,
    output line_t mem_wr_line,
    input  logic  mem_wr_rdy,
    input  logic  mem_wr_done
);

    index_t    index;
    tag_t      tag;
    word_sel_t word_sel;
    way_vec_t  tagv_we;
    way_vec_t  dirty_we;
    way_vec_t  data_we;
    way_vec_t  word_we;
    logic      dirty_in;
    line_t     wdata_line;
    word_t     wdata_word;

    way_vec_t  hits;
    tagv_t     tagvs [WAYS];
    way_vec_t  dirtys;
    line_t     lines [WAYS];

    logic      hit;
    way_idx_t  hit_way;
    word_t     sel_rdata;
    word_t     merged;
    logic      victim_dirty;
    tag_t      victim_tag;
    line_t     victim_line;
    way_idx_t  victim;
    logic      plru_access;
    way_idx_t  plru_way;
    word_t     req_wdata;
    strb_t     req_wstrb;

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .we            (we),
        .addr          (addr),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .busy          (busy),
        .done          (done),
        .rdata         (rdata),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_line  (mem_ret_line),
        .mem_wr_req    (mem_wr_req),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_line   (mem_wr_line),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_wr_done   (mem_wr_done),
        .hit           (hit),
        .hit_way       (hit_way),
        .sel_rdata     (sel_rdata),
        .merged        (merged),
        .victim        (victim),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .victim_line   (victim_line),
        .req_wdata     (req_wdata),
        .req_wstrb     (req_wstrb),
        .index         (index),
        .tag           (tag),
        .word_sel      (word_sel),
        .tagv_we       (tagv_we),
        .dirty_we      (dirty_we),
        .data_we       (data_we),
        .word_we       (word_we),
        .dirty_in      (dirty_in),
        .wdata_line    (wdata_line),
        .wdata_word    (wdata_word),
        .plru_access   (plru_access),
        .plru_way      (plru_way)
    );

    for (genvar i = 0; i < WAYS; i++) begin : g_way
        cache_way u_way (
            .clk        (clk),
            .rst        (rst),
            .index      (index),
            .tag        (tag),
            .tagv_we    (tagv_we[i]),
            .dirty_we   (dirty_we[i]),
            .dirty_in   (dirty_in),
            .data_we    (data_we[i]),
            .word_we    (word_we[i]),
            .word_sel   (word_sel),
            .wdata_line (wdata_line),
            .wdata_word (wdata_word),
            .hit        (hits[i]),
            .tagv       (tagvs[i]),
            .dirty      (dirtys[i]),
            .line       (lines[i])
        );
    end

    way_select u_sel (
        .hits         (hits),
        .tagvs        (tagvs),
        .dirtys       (dirtys),
        .lines        (lines),
        .word_sel     (word_sel),
        .wdata        (req_wdata),
        .wstrb        (req_wstrb),
        .victim       (victim),
        .hit          (hit),
        .hit_way      (hit_way),
        .rdata        (sel_rdata),
        .merged       (merged),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line)
    );

    plru_table u_plru (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .access     (plru_access),
        .access_way (plru_way),
        .victim     (victim)
    );

endmodule

//--- verif/mem_model.sv
`timescale 1ns/10ps

module mem_model import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  mem_rd_req,
    input  addr_t mem_rd_addr,
    output logic  mem_rd_rdy,
    output logic  mem_ret_valid,
    output line_t mem_ret_line,
    input  logic  mem_wr_req,
    input  addr_t mem_wr_addr,
    input  line_t mem_wr_line,
    output logic  mem_wr_rdy,
    output logic  mem_wr_done,
    output int    rd_count,
    output int    wr_count
);

    // lines written back so far, keyed by line address
    line_t contents [addr_t];

    // untouched memory, every address bit takes part
    function automatic word_t initial_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9) ^ 32'h5a5a_0ff0;
    endfunction

    function automatic line_t read_line(input addr_t base);
        line_t l;
        if (contents.exists(base)) begin
            return contents[base];
        end
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i] = initial_word(base + 4 * i);
        end
        return l;
    endfunction

    // ends each wait just after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        line_t l;
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_line  = '0;
        mem_wr_rdy    = 1'b0;
        mem_wr_done   = 1'b0;
        rd_count      = 0;
        wr_count      = 0;
        forever begin
            @(negedge clk);
            if (!rst && mem_wr_req) begin
                wr_count++;
                wait_cycles($urandom_range(1, 6));
                mem_wr_rdy = 1'b1;
                contents[mem_wr_addr] = mem_wr_line;
                wait_cycles(1);
                mem_wr_rdy = 1'b0;
                wait_cycles($urandom_range(0, 5));
                mem_wr_done = 1'b1;
                wait_cycles(1);
                mem_wr_done = 1'b0;
            end else if (!rst && mem_rd_req) begin
                rd_count++;
                wait_cycles($urandom_range(1, 6));
                mem_rd_rdy = 1'b1;
                l = read_line(mem_rd_addr);
                wait_cycles(1);
                mem_rd_rdy = 1'b0;
                wait_cycles($urandom_range(0, 5));
                mem_ret_valid = 1'b1;
                mem_ret_line  = l;
                wait_cycles(1);
                mem_ret_valid = 1'b0;
            end
        end
    end

endmodule

//--- verif/tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache import dcache_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 5;

    logic  clk;
    logic  rst;
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
    logic  busy;
    logic  done;
    word_t rdata;
    logic  mem_rd_req;
    addr_t mem_rd_addr;
    logic  mem_rd_rdy;
    logic  mem_ret_valid;
    line_t mem_ret_line;
    logic  mem_wr_req;
    addr_t mem_wr_addr;
    line_t mem_wr_line;
    logic  mem_wr_rdy;
    logic  mem_wr_done;
    int    rd_count;
    int    wr_count;

    // reference cache state, tree PLRU per set
    tag_t       ref_tag   [SETS][WAYS];
    logic       ref_valid [SETS][WAYS];
    logic       ref_dirty [SETS][WAYS];
    logic [2:0] ref_tree  [SETS];
    word_t      shadow    [addr_t];

    word_t exp_q  [$];
    logic  load_q [$];
    word_t cur_exp;
    logic  cur_load;
    logic  exp_hit;
    logic  exp_wb_valid;
    addr_t exp_wb_addr;
    line_t exp_wb_line;
    addr_t exp_rd_addr;

    int errors;
    int failed_tests;
    int wb_expected;
    int miss_expected;

    dcache_top dut0 (
        .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
        .wstrb(wstrb), .busy(busy), .done(done), .rdata(rdata),
        .mem_rd_req(mem_rd_req), .mem_rd_addr(mem_rd_addr), .mem_rd_rdy(mem_rd_rdy),
        .mem_ret_valid(mem_ret_valid), .mem_ret_line(mem_ret_line),
        .mem_wr_req(mem_wr_req), .mem_wr_addr(mem_wr_addr), .mem_wr_line(mem_wr_line),
        .mem_wr_rdy(mem_wr_rdy), .mem_wr_done(mem_wr_done)
    );

    mem_model mem0 (
        .clk(clk), .rst(rst),
        .mem_rd_req(mem_rd_req), .mem_rd_addr(mem_rd_addr), .mem_rd_rdy(mem_rd_rdy),
        .mem_ret_valid(mem_ret_valid), .mem_ret_line(mem_ret_line),
        .mem_wr_req(mem_wr_req), .mem_wr_addr(mem_wr_addr), .mem_wr_line(mem_wr_line),
        .mem_wr_rdy(mem_wr_rdy), .mem_wr_done(mem_wr_done),
        .rd_count(rd_count), .wr_count(wr_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a request never completed", NUM_TESTS * 400);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // same contents the memory starts with
    function automatic word_t initial_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9) ^ 32'h5a5a_0ff0;
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return initial_word(wa);
    endfunction

    function automatic line_t shadow_line(input addr_t base);
        line_t l;
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i] = shadow_word(base + 4 * i);
        end
        return l;
    endfunction

    function automatic word_t apply_strobe(input word_t old_w, input word_t new_w,
                                           input strb_t s);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    // bit 0 picks pair {0,1} or {2,3}, then bit 1 or bit 2 inside the pair
    function automatic int plru_victim(input logic [2:0] bits);
        if (!bits[0]) begin
            return bits[1] ? 1 : 0;
        end
        return bits[2] ? 3 : 2;
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] bits, input int way);
        logic [2:0] nb;
        nb    = bits;
        nb[0] = (way < 2);
        if (way < 2) begin
            nb[1] = (way == 0);
        end else begin
            nb[2] = (way == 2);
        end
        return nb;
    endfunction

    // predicts hit or miss, updates the reference and presents the request
    task automatic issue(input logic w, input addr_t a, input word_t d, input strb_t s);
        int   set;
        int   way;
        tag_t t;
        set = int'(a[OFFSET_BITS +: INDEX_BITS]);
        t   = a[31 -: TAG_BITS];
        way = -1;
        for (int i = 0; i < WAYS; i++) begin
            if (ref_valid[set][i] && ref_tag[set][i] == t) begin
                way = i;
            end
        end
        exp_hit      = (way >= 0);
        exp_wb_valid = 1'b0;
        exp_rd_addr  = {a[31:4], 4'h0};
        if (way < 0) begin
            miss_expected++;
            way = plru_victim(ref_tree[set]);
            if (ref_valid[set][way] && ref_dirty[set][way]) begin
                exp_wb_valid = 1'b1;
                exp_wb_addr  = {ref_tag[set][way], a[OFFSET_BITS +: INDEX_BITS], 4'h0};
                exp_wb_line  = shadow_line(exp_wb_addr);
                wb_expected++;
            end
            ref_valid[set][way] = 1'b1;
            ref_tag[set][way]   = t;
            ref_dirty[set][way] = 1'b0;
        end
        ref_tree[set] = plru_touch(ref_tree[set], way);
        if (w) begin
            ref_dirty[set][way] = 1'b1;
            shadow[{a[31:2], 2'b00}] = apply_strobe(shadow_word(a), d, s);
        end
        req   = 1'b1;
        we    = w;
        addr  = a;
        wdata = d;
        wstrb = s;
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        exp_q.push_back(shadow_word(a));
        load_q.push_back(!w);
        #2;
    endtask

    task automatic release_req;
        req = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wait_all_done;
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0);
        #2;
    endtask

    task automatic load(input addr_t a);
        issue(1'b0, a, '0, '0);
        release_req();
        wait_all_done();
    endtask

    task automatic store(input addr_t a, input word_t d, input strb_t s);
        issue(1'b1, a, d, s);
        release_req();
        wait_all_done();
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
        end
    endtask

    // each done retires the oldest accepted request
    always @(negedge clk) begin
        if (!rst && done) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("done pulsed at %0t with no request outstanding", $time);
            end else begin
                cur_exp  = exp_q.pop_front();
                cur_load = load_q.pop_front();
            end
        end
    end

    reset_quiet: assert property (@(posedge clk)
        $past(rst) |-> !busy && !done && !mem_rd_req && !mem_wr_req)
        else begin
            errors++;
            $display("[FAIL] after reset busy=%h done=%h mem_rd_req=%h mem_wr_req=%h",
                     $sampled(busy), $sampled(done), $sampled(mem_rd_req), $sampled(mem_wr_req));
        end

    hit_timing: assert property (@(posedge clk) disable iff (rst)
        req && !busy && exp_hit |=> done && !busy && !mem_rd_req && !mem_wr_req)
        else begin
            errors++;
            $display("[FAIL] hit cycle done=%h busy=%h mem_rd_req=%h mem_wr_req=%h",
                     $sampled(done), $sampled(busy), $sampled(mem_rd_req), $sampled(mem_wr_req));
        end

    miss_busy: assert property (@(posedge clk) disable iff (rst)
        req && !busy && !exp_hit |=> busy && !done)
        else begin
            errors++;
            $display("[FAIL] miss cycle busy=%h done=%h", $sampled(busy), $sampled(done));
        end

    load_value: assert property (@(posedge clk) disable iff (rst)
        done && cur_load |-> rdata == cur_exp)
        else begin
            errors++;
            $display("[FAIL] rdata got %h expected %h", $sampled(rdata), $sampled(cur_exp));
        end

    refill_addr: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req |-> mem_rd_addr == exp_rd_addr)
        else begin
            errors++;
            $display("[FAIL] mem_rd_addr got %h expected %h",
                     $sampled(mem_rd_addr), $sampled(exp_rd_addr));
        end

    wb_wanted: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req |-> exp_wb_valid)
        else begin
            errors++;
            $display("memory write requested although the victim line was clean");
        end

    wb_addr: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req |-> mem_wr_addr == exp_wb_addr)
        else begin
            errors++;
            $display("[FAIL] mem_wr_addr got %h expected %h",
                     $sampled(mem_wr_addr), $sampled(exp_wb_addr));
        end

    wb_line: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req |-> mem_wr_line == exp_wb_line)
        else begin
            errors++;
            $display("[FAIL] mem_wr_line got %h expected %h",
                     $sampled(mem_wr_line), $sampled(exp_wb_line));
        end

    initial begin
        int    e0;
        int    r0;
        int    w0;
        addr_t a;
        void'($urandom(32'hf156));
        rst   = 1'b1;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        wstrb = '0;
        cur_exp       = '0;
        cur_load      = 1'b0;
        exp_hit       = 1'b0;
        exp_wb_valid  = 1'b0;
        exp_wb_addr   = '0;
        exp_wb_line   = '0;
        exp_rd_addr   = '0;
        errors        = 0;
        failed_tests  = 0;
        wb_expected   = 0;
        miss_expected = 0;
        for (int s = 0; s < SETS; s++) begin
            ref_tree[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        e0 = errors;
        r0 = rd_count;
        load(32'h0000_1040);
        assert (rd_count == r0 + 1) else begin
            errors++;
            $display("first load made %0d line reads instead of one", rd_count - r0);
        end
        end_test(1, "reset and first miss", e0);

        // same line again, then four hits on consecutive cycles
        e0 = errors;
        r0 = rd_count;
        load(32'h0000_1044);
        issue(1'b0, 32'h0000_1040, '0, '0);
        issue(1'b0, 32'h0000_1044, '0, '0);
        issue(1'b0, 32'h0000_1048, '0, '0);
        issue(1'b0, 32'h0000_104c, '0, '0);
        release_req();
        wait_all_done();
        assert (rd_count == r0) else begin
            errors++;
            $display("hits on a cached line went to memory");
        end
        end_test(2, "hit latency", e0);

        e0 = errors;
        store(32'h0000_1048, $urandom(), 4'b0101);
        store(32'h0000_2058, $urandom(), 4'b1110);
        store(32'h0000_3064, $urandom(), 4'b1000);
        store(32'h0000_2058, $urandom(), 4'b0001);
        store(32'h0000_205c, $urandom(), 4'b1111);
        load(32'h0000_1048);
        load(32'h0000_2058);
        load(32'h0000_3064);
        load(32'h0000_205c);
        load(32'h0000_2050);
        end_test(3, "byte enable stores", e0);

        // five lines in set 8, the dirty first one is the victim
        e0 = errors;
        w0 = wr_count;
        store(32'h0000_4084, $urandom(), 4'b0011);
        for (int k = 1; k <= 4; k++) begin
            load(32'h0000_4080 + k * 32'h400);
        end
        assert (wr_count == w0 + 1) else begin
            errors++;
            $display("dirty eviction made %0d memory writes instead of one", wr_count - w0);
        end
        load(32'h0000_4084);
        end_test(4, "dirty eviction", e0);

        // random traffic over six lines of set 12
        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            a = 32'h0001_00c0 + ($urandom_range(0, 5) << 10) + ($urandom_range(0, 3) << 2);
            if ($urandom_range(0, 1) == 1) begin
                store(a, $urandom(), 4'($urandom_range(1, 15)));
            end else begin
                load(a);
            end
        end
        for (int k = 0; k < 6; k++) begin
            load(32'h0001_00c0 + (k << 10));
        end
        assert (rd_count == miss_expected && wr_count == wb_expected) else begin
            errors++;
            $display("memory traffic differs from the PLRU model: %0d/%0d reads, %0d/%0d writes",
                     rd_count, miss_expected, wr_count, wb_expected);
        end
        end_test(5, "plru order", e0);

        $display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
src/dcache_pkg.sv
src/lutram.sv
src/cache_way.sv
src/plru_table.sv
src/way_select.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/mem_model.sv
verif/tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the data cache testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_dcache -Mdir obj_dir -f all.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dcache 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
exit 1
